/* cnn_layer_top.f */
hw/cnn_pkg.sv
hw/cfg_regs.sv
hw/group_mac.sv
hw/sum_pool.sv
hw/post_ops.sv
hw/layers.sv
hw/cnn_layer_top.sv
tests/cnn_layer_chk.sv
tests/cnn_layer_tb.sv

/* hw/cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [cnn_pkg::CFG_AWIDTH-1:0]      wb_adr,
    input  logic [cnn_pkg::CFG_DWIDTH-1:0]      wb_dat_w,
    output logic                                wb_ack,
    output logic [cnn_pkg::CFG_DWIDTH-1:0]      wb_dat_r,
    output logic                                bypass,
    output logic [cnn_pkg::CFG_FIELD_WIDTH-1:0] pool_nb,
    output logic [cnn_pkg::CFG_FIELD_WIDTH-1:0] shift
);

    logic req;
    logic req_q;
    logic cfg_hit;

    assign req = wb_cyc & wb_stb;
    assign cfg_hit = (wb_adr == cnn_pkg::CFG_LAYERS);

    // ack once per request, rearmed when stb drops
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
            wb_ack <= 1'b0;
        end else begin
            req_q <= req;
            wb_ack <= req & ~req_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bypass <= 1'b1;
            pool_nb <= '0;
            shift <= '0;
        end else if (wb_ack && req && wb_we && cfg_hit) begin
            bypass <= wb_dat_w[cnn_pkg::CFG_BYPASS_BIT];
            pool_nb <= wb_dat_w[cnn_pkg::CFG_POOL_LSB +: cnn_pkg::CFG_FIELD_WIDTH];
            shift <= wb_dat_w[cnn_pkg::CFG_SHIFT_LSB +: cnn_pkg::CFG_FIELD_WIDTH];
        end
    end

    always_comb begin
        wb_dat_r = '0;
        if (cfg_hit) begin
            wb_dat_r[cnn_pkg::CFG_BYPASS_BIT] = bypass;
            wb_dat_r[cnn_pkg::CFG_POOL_LSB +: cnn_pkg::CFG_FIELD_WIDTH] = pool_nb;
            wb_dat_r[cnn_pkg::CFG_SHIFT_LSB +: cnn_pkg::CFG_FIELD_WIDTH] = shift;
        end
    end

endmodule

`default_nettype wire

/* hw/cnn_layer_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cnn_layer_top (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              wb_cyc,
    input  logic                                              wb_stb,
    input  logic                                              wb_we,
    input  logic [cnn_pkg::CFG_AWIDTH-1:0]                    wb_adr,
    input  logic [cnn_pkg::CFG_DWIDTH-1:0]                    wb_dat_w,
    output logic                                              wb_ack,
    output logic [cnn_pkg::CFG_DWIDTH-1:0]                    wb_dat_r,
    input  logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_WIDTH-1:0]   bias_bus,
    input  logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_LANES_W-1:0] kernel_bus,
    output logic                                              kernel_rdy,
    input  logic [cnn_pkg::IMG_LANES_W-1:0]                   image_bus,
    input  logic                                              image_last,
    input  logic                                              image_val,
    output logic                                              image_rdy,
    output logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0]   result_bus,
    output logic                                              result_val,
    input  logic                                              result_rdy
);

    logic                                bypass;
    logic [cnn_pkg::CFG_FIELD_WIDTH-1:0] pool_nb;
    logic [cnn_pkg::CFG_FIELD_WIDTH-1:0] shift;

    cfg_regs cfg_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .bypass   (bypass),
        .pool_nb  (pool_nb),
        .shift    (shift)
    );

    layers layers_inst (
        .clk        (clk),
        .rst        (rst),
        .bypass     (bypass),
        .pool_nb    (pool_nb),
        .shift      (shift),
        .bias_bus   (bias_bus),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

endmodule

`default_nettype wire

/* hw/cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

    // datapath widths
    localparam int IMG_WIDTH = 16;
    localparam int KER_WIDTH = 16;
    localparam int GROUP_NB = 2;
    localparam int DEPTH_NB = 2;
    localparam int NUM_WIDTH = IMG_WIDTH + KER_WIDTH + 1;

    // packed lane groups of one channel
    localparam int IMG_LANES_W = GROUP_NB * IMG_WIDTH;
    localparam int KER_LANES_W = GROUP_NB * KER_WIDTH;
    localparam int SUM_LANES_W = GROUP_NB * NUM_WIDTH;

    // wishbone configuration map
    localparam int CFG_AWIDTH = 4;
    localparam int CFG_DWIDTH = 32;
    localparam logic [CFG_AWIDTH-1:0] CFG_LAYERS = 2;
    localparam int CFG_BYPASS_BIT = 16;
    localparam int CFG_POOL_LSB = 8;
    localparam int CFG_SHIFT_LSB = 0;
    localparam int CFG_FIELD_WIDTH = 8;

    // one-hot state bit positions
    localparam int UP_RESET = 0;
    localparam int UP_READY = 1;
    localparam int UP_DONE = 2;
    localparam int UP_CLEAR = 3;
    localparam int DN_RESET = 0;
    localparam int DN_READY = 1;
    localparam int DN_ADD = 2;
    localparam int DN_POOL = 3;
    localparam int DN_OPS = 4;
    localparam int DN_CLEAR = 5;

endpackage

`default_nettype wire

/* hw/group_mac.sv */
`timescale 1ns/10ps
`default_nettype none

module group_mac (
    input  logic                            clk,
    input  logic                            restart,
    input  logic [cnn_pkg::IMG_LANES_W-1:0] img,
    input  logic [cnn_pkg::KER_LANES_W-1:0] ker,
    input  logic                            kernel_rdy,
    output logic [cnn_pkg::SUM_LANES_W-1:0] sums
);

    for (genvar lane = 0; lane < cnn_pkg::GROUP_NB; lane++) begin : lane_mac
        logic signed [cnn_pkg::NUM_WIDTH-1:0] acc;
        logic signed [cnn_pkg::IMG_WIDTH-1:0] pix;
        logic signed [cnn_pkg::KER_WIDTH-1:0] coef;

        assign pix = img[lane*cnn_pkg::IMG_WIDTH +: cnn_pkg::IMG_WIDTH];
        assign coef = ker[lane*cnn_pkg::KER_WIDTH +: cnn_pkg::KER_WIDTH];

        // product is sign extended to the accumulator width
        always_ff @(posedge clk) begin
            if (restart) begin
                acc <= '0;
            end else if (kernel_rdy) begin
                acc <= acc + pix * coef;
            end
        end

        assign sums[lane*cnn_pkg::NUM_WIDTH +: cnn_pkg::NUM_WIDTH] = acc;
    end

endmodule

`default_nettype wire

/* hw/layers.sv */
`timescale 1ns/10ps
`default_nettype none

module layers (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              bypass,
    input  logic [cnn_pkg::CFG_FIELD_WIDTH-1:0]               pool_nb,
    input  logic [cnn_pkg::CFG_FIELD_WIDTH-1:0]               shift,
    input  logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_WIDTH-1:0]   bias_bus,
    input  logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_LANES_W-1:0] kernel_bus,
    output logic                                              kernel_rdy,
    input  logic [cnn_pkg::IMG_LANES_W-1:0]                   image_bus,
    input  logic                                              image_last,
    input  logic                                              image_val,
    output logic                                              image_rdy,
    output logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0]   result_bus,
    output logic                                              result_val,
    input  logic                                              result_rdy
);

    logic [3:0]                                              up_state;
    logic [3:0]                                              up_state_nx;
    logic [5:0]                                              dn_state;
    logic [5:0]                                              dn_state_nx;
    logic                                                    img_xfer;
    logic                                                    handover;
    logic                                                    group_done;
    logic                                                    mac_restart;
    logic                                                    pool_restart;
    logic [6:0]                                              mac_pipe;
    logic [4:0]                                              add_pipe;
    logic [9:0]                                              ops_pipe;
    logic [cnn_pkg::CFG_FIELD_WIDTH-1:0]                     pool_cnt;
    logic [cnn_pkg::IMG_LANES_W-1:0]                         image_q;
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::SUM_LANES_W-1:0]       mac_data;
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::SUM_LANES_W-1:0]       hold;
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::NUM_WIDTH-1:0]         pool_data;
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0]         ops_data;

    assign img_xfer = image_val & image_rdy;
    assign handover = up_state[cnn_pkg::UP_CLEAR] & dn_state[cnn_pkg::DN_READY];
    assign group_done = dn_state[cnn_pkg::DN_POOL] & (pool_cnt >= pool_nb);
    assign image_rdy = up_state[cnn_pkg::UP_READY];
    assign result_val = dn_state[cnn_pkg::DN_CLEAR];

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= 4'(1 << cnn_pkg::UP_RESET);
            dn_state <= 6'(1 << cnn_pkg::DN_RESET);
        end else begin
            up_state <= up_state_nx;
            dn_state <= dn_state_nx;
        end
    end

    // upstream side owns the MAC bank until the window is handed over
    always_comb begin
        up_state_nx = '0;
        case (1'b1)
            up_state[cnn_pkg::UP_RESET]: up_state_nx[cnn_pkg::UP_READY] = 1'b1;
            up_state[cnn_pkg::UP_READY]: begin
                if (img_xfer && image_last) up_state_nx[cnn_pkg::UP_DONE] = 1'b1;
                else up_state_nx[cnn_pkg::UP_READY] = 1'b1;
            end
            up_state[cnn_pkg::UP_DONE]: begin
                if (mac_pipe[6]) up_state_nx[cnn_pkg::UP_CLEAR] = 1'b1;
                else up_state_nx[cnn_pkg::UP_DONE] = 1'b1;
            end
            up_state[cnn_pkg::UP_CLEAR]: begin
                if (dn_state[cnn_pkg::DN_READY]) up_state_nx[cnn_pkg::UP_RESET] = 1'b1;
                else up_state_nx[cnn_pkg::UP_CLEAR] = 1'b1;
            end
            default: up_state_nx[cnn_pkg::UP_RESET] = 1'b1;
        endcase
    end

    always_comb begin
        dn_state_nx = '0;
        case (1'b1)
            dn_state[cnn_pkg::DN_RESET]: dn_state_nx[cnn_pkg::DN_READY] = 1'b1;
            dn_state[cnn_pkg::DN_READY]: begin
                if (up_state[cnn_pkg::UP_CLEAR]) dn_state_nx[cnn_pkg::DN_ADD] = 1'b1;
                else dn_state_nx[cnn_pkg::DN_READY] = 1'b1;
            end
            dn_state[cnn_pkg::DN_ADD]: begin
                if (add_pipe[4]) dn_state_nx[cnn_pkg::DN_POOL] = 1'b1;
                else dn_state_nx[cnn_pkg::DN_ADD] = 1'b1;
            end
            dn_state[cnn_pkg::DN_POOL]: begin
                if (group_done) dn_state_nx[cnn_pkg::DN_OPS] = 1'b1;
                else dn_state_nx[cnn_pkg::DN_READY] = 1'b1;
            end
            dn_state[cnn_pkg::DN_OPS]: begin
                if (ops_pipe[9]) dn_state_nx[cnn_pkg::DN_CLEAR] = 1'b1;
                else dn_state_nx[cnn_pkg::DN_OPS] = 1'b1;
            end
            dn_state[cnn_pkg::DN_CLEAR]: begin
                if (result_rdy) dn_state_nx[cnn_pkg::DN_RESET] = 1'b1;
                else dn_state_nx[cnn_pkg::DN_CLEAR] = 1'b1;
            end
            default: dn_state_nx[cnn_pkg::DN_RESET] = 1'b1;
        endcase
    end

    // valid pipelines track the datapath latencies
    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            mac_restart <= 1'b1;
            pool_restart <= 1'b1;
            mac_pipe <= '0;
            add_pipe <= '0;
            ops_pipe <= '0;
        end else begin
            kernel_rdy <= img_xfer;
            mac_restart <= up_state[cnn_pkg::UP_RESET];
            pool_restart <= dn_state[cnn_pkg::DN_RESET];
            mac_pipe <= {mac_pipe[5:0], img_xfer & image_last};
            add_pipe <= {add_pipe[3:0], handover};
            ops_pipe <= {ops_pipe[8:0], group_done};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || dn_state[cnn_pkg::DN_RESET]) begin
            pool_cnt <= '0;
        end else if (dn_state[cnn_pkg::DN_POOL]) begin
            pool_cnt <= group_done ? '0 : pool_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (img_xfer) image_q <= image_bus;
        if (mac_pipe[6]) hold <= mac_data;
        if (ops_pipe[9]) result_bus <= ops_data;
    end

    for (genvar ch = 0; ch < cnn_pkg::DEPTH_NB; ch++) begin : chan
        group_mac group_mac_inst (
            .clk        (clk),
            .restart    (mac_restart),
            .img        (image_q),
            .ker        (kernel_bus[ch*cnn_pkg::KER_LANES_W +: cnn_pkg::KER_LANES_W]),
            .kernel_rdy (kernel_rdy),
            .sums       (mac_data[ch*cnn_pkg::SUM_LANES_W +: cnn_pkg::SUM_LANES_W])
        );

        sum_pool sum_pool_inst (
            .clk       (clk),
            .restart   (pool_restart),
            .lanes     (hold[ch*cnn_pkg::SUM_LANES_W +: cnn_pkg::SUM_LANES_W]),
            .sum_valid (add_pipe[4]),
            .pooled    (pool_data[ch*cnn_pkg::NUM_WIDTH +: cnn_pkg::NUM_WIDTH])
        );

        post_ops post_ops_inst (
            .clk    (clk),
            .bypass (bypass),
            .shift  (shift),
            .bias   (bias_bus[ch*cnn_pkg::KER_WIDTH +: cnn_pkg::KER_WIDTH]),
            .pooled (pool_data[ch*cnn_pkg::NUM_WIDTH +: cnn_pkg::NUM_WIDTH]),
            .pixel  (ops_data[ch*cnn_pkg::IMG_WIDTH +: cnn_pkg::IMG_WIDTH])
        );
    end

endmodule

`default_nettype wire

/* hw/post_ops.sv */
`timescale 1ns/10ps
`default_nettype none

module post_ops (
    input  logic                                clk,
    input  logic                                bypass,
    input  logic [cnn_pkg::CFG_FIELD_WIDTH-1:0] shift,
    input  logic [cnn_pkg::KER_WIDTH-1:0]       bias,
    input  logic [cnn_pkg::NUM_WIDTH-1:0]       pooled,
    output logic [cnn_pkg::IMG_WIDTH-1:0]       pixel
);

    // one guard bit above the accumulator for the bias add
    logic signed [cnn_pkg::NUM_WIDTH:0]                    biased;
    logic signed [cnn_pkg::NUM_WIDTH:0]                    rectified;
    logic signed [cnn_pkg::NUM_WIDTH:0]                    scaled;
    logic [cnn_pkg::NUM_WIDTH-cnn_pkg::IMG_WIDTH+1:0]      upper;

    always_ff @(posedge clk) begin
        biased <= $signed(pooled) + $signed(bias);
    end

    always_ff @(posedge clk) begin
        if (!bypass && biased[cnn_pkg::NUM_WIDTH]) begin
            rectified <= '0;
        end else begin
            rectified <= biased;
        end
    end

    assign scaled = rectified >>> shift;
    assign upper = scaled[cnn_pkg::NUM_WIDTH:cnn_pkg::IMG_WIDTH-1];

    // in range when all bits above the result sign match it
    always_ff @(posedge clk) begin
        if ((&upper) || !(|upper)) begin
            pixel <= scaled[cnn_pkg::IMG_WIDTH-1:0];
        end else if (scaled[cnn_pkg::NUM_WIDTH]) begin
            pixel <= {1'b1, {(cnn_pkg::IMG_WIDTH-1){1'b0}}};
        end else begin
            pixel <= {1'b0, {(cnn_pkg::IMG_WIDTH-1){1'b1}}};
        end
    end

endmodule

`default_nettype wire

/* hw/sum_pool.sv */
`timescale 1ns/10ps
`default_nettype none

module sum_pool (
    input  logic                            clk,
    input  logic                            restart,
    input  logic [cnn_pkg::SUM_LANES_W-1:0] lanes,
    input  logic                            sum_valid,
    output logic [cnn_pkg::NUM_WIDTH-1:0]   pooled
);

    logic [cnn_pkg::NUM_WIDTH-1:0] lane_total;
    logic [cnn_pkg::NUM_WIDTH-1:0] sum_q;
    logic [cnn_pkg::NUM_WIDTH-1:0] pool_q;
    logic                          first;

    always_comb begin
        lane_total = '0;
        for (int i = 0; i < cnn_pkg::GROUP_NB; i++) begin
            lane_total = lane_total + lanes[i*cnn_pkg::NUM_WIDTH +: cnn_pkg::NUM_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        sum_q <= lane_total;
    end

    // first window of a group loads, later ones keep the max
    always_ff @(posedge clk) begin
        if (restart) begin
            first <= 1'b1;
        end else if (sum_valid) begin
            first <= 1'b0;
            if (first || ($signed(sum_q) > $signed(pool_q))) begin
                pool_q <= sum_q;
            end
        end
    end

    assign pooled = pool_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cnn layer testbench with verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cnn_layer_tb \
    -f cnn_layer_top.f -o cnn_layer_sim > sim.log 2>&1 \
    && ./obj_dir/cnn_layer_sim >> sim.log 2>&1 \
    || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* tests/cnn_layer_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cnn_layer_chk (
    input logic                                            clk,
    input logic                                            rst,
    input logic [3:0]                                      up_state,
    input logic [5:0]                                      dn_state,
    input logic                                            image_val,
    input logic                                            image_rdy,
    input logic                                            kernel_rdy,
    input logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] result_bus,
    input logic                                            result_val,
    input logic                                            result_rdy,
    input logic                                            wb_ack
);

    up_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(up_state))
        else $error("upstream state vector is not one-hot");

    dn_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(dn_state))
        else $error("downstream state vector is not one-hot");

    // a stalled result keeps its word and its valid
    result_hold: assert property (@(posedge clk) disable iff (rst)
        result_val && !result_rdy |=> result_val && $stable(result_bus))
        else $error("result changed while stalled");

    kernel_after_beat: assert property (@(posedge clk) disable iff (rst)
        kernel_rdy |-> $past(image_val && image_rdy))
        else $error("kernel_rdy without a preceding image transfer");

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

endmodule

bind cnn_layer_top cnn_layer_chk cnn_layer_chk_inst (
    .clk        (clk),
    .rst        (rst),
    .up_state   (layers_inst.up_state),
    .dn_state   (layers_inst.dn_state),
    .image_val  (image_val),
    .image_rdy  (image_rdy),
    .kernel_rdy (kernel_rdy),
    .result_bus (result_bus),
    .result_val (result_val),
    .result_rdy (result_rdy),
    .wb_ack     (wb_ack)
);

`default_nettype wire

/* tests/cnn_layer_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cnn_layer_tb;

    logic                                              clk;
    logic                                              rst;
    logic                                              wb_cyc;
    logic                                              wb_stb;
    logic                                              wb_we;
    logic [cnn_pkg::CFG_AWIDTH-1:0]                    wb_adr;
    logic [cnn_pkg::CFG_DWIDTH-1:0]                    wb_dat_w;
    logic                                              wb_ack;
    logic [cnn_pkg::CFG_DWIDTH-1:0]                    wb_dat_r;
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_WIDTH-1:0]   bias_bus;
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_LANES_W-1:0] kernel_bus;
    logic                                              kernel_rdy;
    logic [cnn_pkg::IMG_LANES_W-1:0]                   image_bus;
    logic                                              image_last;
    logic                                              image_val;
    logic                                              image_rdy;
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0]   result_bus;
    logic                                              result_val;
    logic                                              result_rdy;

    // window stimulus, indexed by window then beat
    logic [cnn_pkg::IMG_LANES_W-1:0]                   win_img [4][4];
    logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_LANES_W-1:0] win_ker [4][4];

    int timeout_cycles = 200;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    bit hung = 1'b0;

    cnn_layer_top cnn_layer_top_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .bias_bus   (bias_bus),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [cnn_pkg::CFG_DWIDTH-1:0] exp,
                              input logic [cnn_pkg::CFG_DWIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_result(input string name,
                                input logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] exp,
                                input logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [cnn_pkg::CFG_DWIDTH-1:0] cfg_word(input logic byp,
            input logic [7:0] pool, input logic [7:0] sh);
        logic [cnn_pkg::CFG_DWIDTH-1:0] word;
        word = '0;
        word[cnn_pkg::CFG_BYPASS_BIT] = byp;
        word[cnn_pkg::CFG_POOL_LSB +: 8] = pool;
        word[cnn_pkg::CFG_SHIFT_LSB +: 8] = sh;
        return word;
    endfunction

    task automatic wb_write(input logic [cnn_pkg::CFG_AWIDTH-1:0] adr,
                            input logic [cnn_pkg::CFG_DWIDTH-1:0] dat);
        int wait_cnt;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr;
        wb_dat_w = dat;
        wait_cnt = 0;
        while (!hung && !wb_ack && wait_cnt < timeout_cycles) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (!hung && !wb_ack) begin
            hung = 1'b1;
            $display("timeout: no wb_ack for the write to address %0d", adr);
        end else if (wb_ack) begin
            // the register takes the data on the acknowledged edge
            @(posedge clk);
            #2;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic wb_read(input logic [cnn_pkg::CFG_AWIDTH-1:0] adr,
                           input logic [cnn_pkg::CFG_DWIDTH-1:0] exp, input string name);
        int wait_cnt;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr;
        wait_cnt = 0;
        while (!hung && !wb_ack && wait_cnt < timeout_cycles) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (!hung && !wb_ack) begin
            hung = 1'b1;
            $display("timeout: no wb_ack for the read of address %0d", adr);
        end else if (wb_ack) begin
            check_word(name, exp, wb_dat_r);
            @(posedge clk);
            #2;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic set_config(input logic byp, input logic [7:0] pool, input logic [7:0] sh);
        wb_write(cnn_pkg::CFG_LAYERS, cfg_word(byp, pool, sh));
    endtask

    function automatic logic [15:0] rand_val(input int range);
        int v;
        v = int'($urandom_range(2 * range)) - range;
        return v[15:0];
    endfunction

    task automatic fill_window(input int w, input int beats, input int range);
        for (int b = 0; b < beats; b++) begin
            for (int l = 0; l < cnn_pkg::GROUP_NB; l++) begin
                win_img[w][b][l*cnn_pkg::IMG_WIDTH +: cnn_pkg::IMG_WIDTH] = rand_val(range);
            end
            for (int k = 0; k < cnn_pkg::DEPTH_NB * cnn_pkg::GROUP_NB; k++) begin
                win_ker[w][b][k*cnn_pkg::KER_WIDTH +: cnn_pkg::KER_WIDTH] = rand_val(range);
            end
        end
    endtask

    // reference: lane products summed over all beats of one window
    function automatic longint window_sum(input int w, input int beats, input int ch);
        longint acc;
        logic signed [cnn_pkg::IMG_WIDTH-1:0] pix;
        logic signed [cnn_pkg::KER_WIDTH-1:0] ker;
        acc = 0;
        for (int b = 0; b < beats; b++) begin
            for (int l = 0; l < cnn_pkg::GROUP_NB; l++) begin
                pix = win_img[w][b][l*cnn_pkg::IMG_WIDTH +: cnn_pkg::IMG_WIDTH];
                ker = win_ker[w][b][(ch*cnn_pkg::GROUP_NB+l)*cnn_pkg::KER_WIDTH +: 16];
                acc += longint'(pix) * longint'(ker);
            end
        end
        return acc;
    endfunction

    // reference: max pool, bias, optional relu, shift and saturate per channel
    function automatic logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] group_result(
            input int w0, input int nwin, input int beats,
            input logic [cnn_pkg::DEPTH_NB*cnn_pkg::KER_WIDTH-1:0] bias,
            input bit relu, input int sh);
        logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] res;
        logic signed [cnn_pkg::KER_WIDTH-1:0] b;
        longint best;
        longint v;
        longint top;
        top = (longint'(1) <<< (cnn_pkg::IMG_WIDTH - 1)) - 1;
        for (int ch = 0; ch < cnn_pkg::DEPTH_NB; ch++) begin
            best = window_sum(w0, beats, ch);
            for (int w = w0 + 1; w < w0 + nwin; w++) begin
                v = window_sum(w, beats, ch);
                if (v > best) best = v;
            end
            b = bias[ch*cnn_pkg::KER_WIDTH +: cnn_pkg::KER_WIDTH];
            v = best + longint'(b);
            if (relu && v < 0) v = 0;
            v = v >>> sh;
            if (v > top) v = top;
            else if (v < -top - 1) v = -top - 1;
            res[ch*cnn_pkg::IMG_WIDTH +: cnn_pkg::IMG_WIDTH] = v[cnn_pkg::IMG_WIDTH-1:0];
        end
        return res;
    endfunction

    // kernel for a beat goes out in the cycle after that beat transfers
    task automatic send_window(input int w, input int beats);
        int wait_cnt;
        for (int b = 0; b < beats && !hung; b++) begin
            image_bus = win_img[w][b];
            image_last = (b == beats - 1);
            image_val = 1'b1;
            wait_cnt = 0;
            while (!hung && !image_rdy && wait_cnt < timeout_cycles) begin
                @(posedge clk);
                #2;
                wait_cnt++;
            end
            if (!hung && !image_rdy) begin
                hung = 1'b1;
                $display("timeout: image_rdy stayed low on window %0d beat %0d", w, b);
            end else if (image_rdy) begin
                @(posedge clk);
                #2;
                if (!kernel_rdy) begin
                    errors++;
                    $display("kernel_rdy low after the transfer of window %0d beat %0d", w, b);
                end
                kernel_bus = win_ker[w][b];
            end
        end
        image_val = 1'b0;
        image_last = 1'b0;
    endtask

    task automatic get_result(input string name,
                              input logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] exp,
                              input int hold);
        int wait_cnt;
        wait_cnt = 0;
        while (!hung && !result_val && wait_cnt < timeout_cycles) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (!hung && !result_val) begin
            hung = 1'b1;
            $display("timeout: result_val never rose in %s", name);
        end else if (result_val) begin
            for (int k = 0; k < hold; k++) begin
                @(posedge clk);
                #2;
                if (!result_val) begin
                    errors++;
                    $display("result_val dropped while the consumer stalled in %s", name);
                end
            end
            check_result(name, exp, result_bus);
            result_rdy = 1'b1;
            @(posedge clk);
            #2;
            result_rdy = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0 && !hung) $display("%s: ok", name);
        else $display("%s: failed", name);
    endtask

    task automatic test_config();
        int err0;
        err0 = errors;
        wb_write(cnn_pkg::CFG_LAYERS, cfg_word(1'b0, 8'h5a, 8'h03));
        wb_read(cnn_pkg::CFG_LAYERS, cfg_word(1'b0, 8'h5a, 8'h03), "config readback");
        wb_read(4'd5, '0, "unused address");
        report_test("config register", err0);
    endtask

    task automatic test_single_window();
        int err0;
        err0 = errors;
        set_config(1'b1, 8'd0, 8'd0);
        fill_window(0, 3, 100);
        bias_bus = {rand_val(1000), rand_val(1000)};
        send_window(0, 3);
        get_result("single random", group_result(0, 1, 3, bias_bus, 1'b0, 0), 0);
        // channel 0 saturates high, channel 1 low
        win_img[0][0] = {16'sd30000, 16'sd30000};
        win_ker[0][0] = {-16'sd30000, -16'sd30000, 16'sd30000, 16'sd30000};
        bias_bus = '0;
        send_window(0, 1);
        get_result("single saturate", group_result(0, 1, 1, bias_bus, 1'b0, 0), 0);
        report_test("single window", err0);
    endtask

    task automatic test_relu();
        int err0;
        err0 = errors;
        set_config(1'b0, 8'd0, 8'd0);
        win_img[0][0] = {16'sd20, 16'sd10};
        win_ker[0][0] = {-16'sd6, -16'sd5, 16'sd4, 16'sd3};
        bias_bus = {16'sd2, 16'sd5};
        send_window(0, 1);
        get_result("relu", group_result(0, 1, 1, bias_bus, 1'b1, 0), 0);
        report_test("relu", err0);
    endtask

    task automatic test_pool_shift();
        int err0;
        err0 = errors;
        set_config(1'b1, 8'd2, 8'd3);
        for (int w = 0; w < 3; w++) fill_window(w, 2, 200);
        bias_bus = {rand_val(1000), rand_val(1000)};
        for (int w = 0; w < 3; w++) send_window(w, 2);
        get_result("pool shift", group_result(0, 3, 2, bias_bus, 1'b0, 3), 0);
        report_test("max pool and shift", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        int hold;
        logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] exp0;
        logic [cnn_pkg::DEPTH_NB*cnn_pkg::IMG_WIDTH-1:0] exp1;
        err0 = errors;
        set_config(1'b1, 8'd1, 8'd0);
        for (int w = 0; w < 4; w++) fill_window(w, 2, 300);
        bias_bus = {rand_val(1000), rand_val(1000)};
        hold = $urandom_range(20, 5);
        exp0 = group_result(0, 2, 2, bias_bus, 1'b0, 0);
        exp1 = group_result(2, 2, 2, bias_bus, 1'b0, 0);
        send_window(0, 2);
        send_window(1, 2);
        // second group streams in while the first result is stalled
        fork
            begin
                send_window(2, 2);
                send_window(3, 2);
            end
            begin
                get_result("stalled group", exp0, hold);
                get_result("following group", exp1, 0);
            end
        join
        report_test("back-pressure", err0);
    endtask

    initial begin
        void'($urandom(32'he159));
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        bias_bus = '0;
        kernel_bus = '0;
        image_bus = '0;
        image_last = 1'b0;
        image_val = 1'b0;
        result_rdy = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        test_config();
        test_single_window();
        test_relu();
        test_pool_shift();
        test_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !hung) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
